//--- vlog.f
+incdir+logic
logic/addr_decode_pkg.sv
logic/window_capture.sv
logic/modrm_decoder.sv
logic/result_select.sv
logic/addr_decode_top.sv
dv/addr_decode_tb.sv

//--- dv/addr_decode_tb.sv
`timescale 1ns/1ns
`default_nettype none

`include "addr_decode_macros.svh"

module addr_decode_tb;

    import addr_decode_pkg::*;

    // window for the offset tests with byte 0 in the low bits
    // pos0 05/44, pos1 44/8C, pos2 8C/D3, pos3 D3/0E, pos4 0E/28
    localparam logic [`ADDR_WINDOW_BYTES*8-1:0] OFFSET_WINDOW = 48'h28_0E_D3_8C_44_05;

    logic       clk;
    logic       rst_n;
    addr_req_t  in_req;
    logic       in_valid;
    logic       in_ready;
    addr_info_t out_info;
    logic       out_valid;
    logic       out_ready;

    // stimulus table with one entry per test
    string      names [$];
    addr_req_t  reqs [$];
    addr_info_t exps [$];
    logic       table_loaded = 1'b0;

    // table indices accepted by the DUT in order
    int         exp_q [$];
    int         matched = 0;
    int         mon_idx;

    addr_decode_top u_dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_req    (in_req),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .out_info  (out_info),
        .out_valid (out_valid),
        .out_ready (out_ready)
    );

    // 100 ns clock
    initial begin
        clk = 1'b0;
        forever begin
            #50 clk = ~clk;
        end
    end

    // expected result from its fields
    function automatic addr_info_t build_info(
        input logic [`ADDR_LEN_W-1:0] length,
        input disp_size_e             disp_size,
        input logic [2:0]             base_reg,
        input logic                   use_base,
        input logic [2:0]             index_reg,
        input logic                   use_index,
        input logic [1:0]             scale,
        input logic                   is_sib
    );
        addr_info_t info;
        info.length    = length;
        info.disp_size = disp_size;
        info.base_reg  = base_reg;
        info.use_base  = use_base;
        info.index_reg = index_reg;
        info.use_index = use_index;
        info.scale     = scale;
        info.is_sib    = is_sib;
        return info;
    endfunction

    // request from a byte window and the opcode fields
    function automatic addr_req_t pack_request(
        input logic [`ADDR_WINDOW_BYTES*8-1:0] bytes,
        input logic [1:0]                      prefix_count,
        input logic                            is_double_op,
        input logic                            has_modrm
    );
        addr_req_t req;
        req.window       = bytes;
        req.prefix_count = prefix_count;
        req.is_double_op = is_double_op;
        req.has_modrm    = has_modrm;
        return req;
    endfunction

    task automatic add_test(input string name, input addr_req_t req, input addr_info_t exp);
        names.push_back(name);
        reqs.push_back(req);
        exps.push_back(exp);
    endtask

    task automatic build_table();
        addr_info_t pos_info [`ADDR_MODRM_POSITIONS];
        int         p;
        int         d;
        // without ModRM the base and index still follow the raw rm and SIB index fields
        add_test("no_modrm_off0", pack_request(OFFSET_WINDOW, 2'd0, 1'b0, 1'b0),
                 build_info(0, disp_none, 3'b101, 1'b0, 3'b000, 1'b0, 2'd0, 1'b0));
        add_test("no_modrm_off2", pack_request(OFFSET_WINDOW, 2'd1, 1'b1, 1'b0),
                 build_info(0, disp_none, 3'b100, 1'b0, 3'b010, 1'b0, 2'd0, 1'b0));
        // mod modes at offset 0
        // byte 1 is 3A so the index field reads 111
        add_test("mod00_rm000", pack_request({32'h66554433, 8'h3A, 8'h00}, 2'd0, 1'b0, 1'b1),
                 build_info(1, disp_none, 3'b000, 1'b1, 3'b111, 1'b0, 2'd0, 1'b0));
        add_test("mod00_rm101", pack_request({32'h66554433, 8'h3A, 8'h05}, 2'd0, 1'b0, 1'b1),
                 build_info(5, disp_32, 3'b101, 1'b0, 3'b111, 1'b0, 2'd0, 1'b0));
        add_test("mod01_rm000", pack_request({32'h66554433, 8'h3A, 8'h40}, 2'd0, 1'b0, 1'b1),
                 build_info(2, disp_8, 3'b000, 1'b1, 3'b111, 1'b0, 2'd0, 1'b0));
        add_test("mod01_rm101", pack_request({32'h66554433, 8'h3A, 8'h45}, 2'd0, 1'b0, 1'b1),
                 build_info(2, disp_8, 3'b101, 1'b1, 3'b111, 1'b0, 2'd0, 1'b0));
        add_test("mod10_rm000", pack_request({32'h66554433, 8'h3A, 8'h80}, 2'd0, 1'b0, 1'b1),
                 build_info(5, disp_32, 3'b000, 1'b1, 3'b111, 1'b0, 2'd0, 1'b0));
        add_test("mod10_rm101", pack_request({32'h66554433, 8'h3A, 8'h85}, 2'd0, 1'b0, 1'b1),
                 build_info(5, disp_32, 3'b101, 1'b1, 3'b111, 1'b0, 2'd0, 1'b0));
        add_test("mod11_rm000", pack_request({32'h66554433, 8'h3A, 8'hC0}, 2'd0, 1'b0, 1'b1),
                 build_info(1, disp_none, 3'b000, 1'b1, 3'b111, 1'b0, 2'd0, 1'b0));
        add_test("mod11_rm101", pack_request({32'h66554433, 8'h3A, 8'hC5}, 2'd0, 1'b0, 1'b1),
                 build_info(1, disp_none, 3'b101, 1'b1, 3'b111, 1'b0, 2'd0, 1'b0));
        // rm 100 in register mode is a plain register without SIB
        add_test("mod11_rm100", pack_request({32'h66554433, 8'h3A, 8'hC4}, 2'd0, 1'b0, 1'b1),
                 build_info(1, disp_none, 3'b100, 1'b1, 3'b111, 1'b0, 2'd0, 1'b0));
        // SIB in each memory mode
        add_test("sib_mod00", pack_request({32'h0, 8'h5A, 8'h04}, 2'd0, 1'b0, 1'b1),
                 build_info(2, disp_none, 3'b010, 1'b1, 3'b011, 1'b1, 2'd1, 1'b1));
        add_test("sib_mod01", pack_request({32'h0, 8'hB1, 8'h4C}, 2'd0, 1'b0, 1'b1),
                 build_info(3, disp_8, 3'b001, 1'b1, 3'b110, 1'b1, 2'd2, 1'b1));
        add_test("sib_mod10", pack_request({32'h0, 8'hE7, 8'h94}, 2'd0, 1'b0, 1'b1),
                 build_info(6, disp_32, 3'b111, 1'b1, 3'b100, 1'b1, 2'd3, 1'b1));
        // SIB base 101 with mod 00 stays an ordinary base
        add_test("sib_mod00_base101", pack_request({32'h0, 8'h25, 8'h04}, 2'd0, 1'b0, 1'b1),
                 build_info(2, disp_none, 3'b101, 1'b1, 3'b100, 1'b1, 2'd0, 1'b1));
        // decode of each position of the offset window
        pos_info[0] = build_info(5, disp_32, 3'b101, 1'b0, 3'b000, 1'b0, 2'd0, 1'b0);
        pos_info[1] = build_info(3, disp_8, 3'b100, 1'b1, 3'b001, 1'b1, 2'd2, 1'b1);
        pos_info[2] = build_info(6, disp_32, 3'b011, 1'b1, 3'b010, 1'b1, 2'd3, 1'b1);
        pos_info[3] = build_info(1, disp_none, 3'b011, 1'b1, 3'b001, 1'b0, 2'd0, 1'b0);
        pos_info[4] = build_info(1, disp_none, 3'b110, 1'b1, 3'b101, 1'b0, 2'd0, 1'b0);
        // ModRM sits at prefix count plus one for a two-byte opcode
        for (p = 0; p <= `ADDR_MAX_PREFIXES; p++) begin
            for (d = 0; d < 2; d++) begin
                add_test($sformatf("offset_p%0d_d%0d", p, d),
                         pack_request(OFFSET_WINDOW, p[1:0], d[0], 1'b1),
                         pos_info[p + d]);
            end
        end
    endtask

    task automatic check_info(input string name, input addr_info_t exp, input addr_info_t act);
        if (act !== exp) begin
            $display("[FAIL] %s: expected %h, actual %h", name, exp, act);
            $display("tests failed");
            $fatal(1);
        end
    endtask

    task automatic check_disp(input string name, input disp_size_e exp, input disp_size_e act);
        if (act !== exp) begin
            $display("[FAIL] %s disp_size: expected %0d, actual %0d", name, exp, act);
            $display("tests failed");
            $fatal(1);
        end
    endtask

    // hold one request until the DUT takes it
    // called just after a rising edge
    task automatic drive_request(input int idx);
        logic accepted;
        in_req   <= reqs[idx];
        in_valid <= 1'b1;
        accepted = 1'b0;
        while (!accepted) begin
            // in_ready is settled at the falling edge
            @(negedge clk);
            accepted = in_ready;
            if (accepted) begin
                exp_q.push_back(idx);
            end
            @(posedge clk);
        end
    endtask

    // random back-pressure with about three cycles in four ready
    initial begin
        void'($urandom(22));
        out_ready = 1'b0;
        forever begin
            @(posedge clk);
            out_ready <= ($urandom % 4) != 0;
        end
    end

    // output handshake seen at the falling edge
    // the transfer itself happens on the next rising edge
    always @(negedge clk) begin
        if (rst_n && out_valid && out_ready) begin
            if (exp_q.size() == 0) begin
                $display("an output arrived with no request outstanding");
                $display("tests failed");
                $fatal(1);
            end else begin
                mon_idx = exp_q.pop_front();
                check_disp(names[mon_idx], exps[mon_idx].disp_size, out_info.disp_size);
                check_info(names[mon_idx], exps[mon_idx], out_info);
                matched++;
            end
        end
    end

    // watchdog allows twenty cycles per table entry
    initial begin
        wait (table_loaded);
        repeat (reqs.size() * 20) @(posedge clk);
        $display("timeout: outputs stopped arriving");
        $display("tests failed");
        $fatal(1);
    end

    initial begin
        int i;
        rst_n    = 1'b0;
        in_valid = 1'b0;
        in_req   = '0;
        build_table();
        table_loaded = 1'b1;
        // reset low for three cycles
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        if (out_valid !== 1'b0 || in_ready !== 1'b1) begin
            $display("after reset out_valid is not low or in_ready is not high");
            $display("tests failed");
            $fatal(1);
        end
        @(posedge clk);
        // back-to-back requests
        for (i = 0; i < reqs.size(); i++) begin
            drive_request(i);
        end
        in_valid <= 1'b0;
        wait (matched == reqs.size());
        // a few more cycles so a duplicated item would still be held
        repeat (5) @(posedge clk);
        if (out_valid === 1'b0 && in_ready === 1'b1) begin
            $display("all tests passed");
            $finish;
        end else begin
            $display("the DUT still holds an item after every request was matched");
            $display("tests failed");
            $fatal(1);
        end
    end

endmodule

`default_nettype wire

//--- logic/addr_decode_top.sv
`timescale 1ns/1ns
`default_nettype none

`include "addr_decode_macros.svh"

module addr_decode_top (
    input  logic                        clk,
    input  logic                        rst_n,
    input  addr_decode_pkg::addr_req_t  in_req,
    input  logic                        in_valid,
    output logic                        in_ready,
    output addr_decode_pkg::addr_info_t out_info,
    output logic                        out_valid,
    input  logic                        out_ready
);

    import addr_decode_pkg::*;

    // registered window between the two stages
    window_stage_t                          stage;
    logic                                   stage_valid;
    logic                                   stage_ready;
    // one decode per possible ModRM position
    addr_info_t [`ADDR_MODRM_POSITIONS-1:0] candidates;

    // feeder, registers the window and the ModRM offset
    window_capture u_capture (
        .clk         (clk),
        .rst_n       (rst_n),
        .in_req      (in_req),
        .in_valid    (in_valid),
        .in_ready    (in_ready),
        .stage       (stage),
        .stage_valid (stage_valid),
        .stage_ready (stage_ready)
    );

    // decoder k sees byte k as ModRM and byte k+1 as SIB
    for (genvar k = 0; k < `ADDR_MODRM_POSITIONS; k++) begin : g_dec
        modrm_decoder u_dec (
            .modrm_byte (stage.window[k]),
            .sib_byte   (stage.window[k+1]),
            .has_modrm  (stage.has_modrm),
            .info       (candidates[k])
        );
    end

    // drain, picks the decoder at the offset and registers it
    result_select u_select (
        .clk         (clk),
        .rst_n       (rst_n),
        .offset      (stage.offset),
        .candidates  (candidates),
        .stage_valid (stage_valid),
        .stage_ready (stage_ready),
        .out_info    (out_info),
        .out_valid   (out_valid),
        .out_ready   (out_ready)
    );

endmodule

`default_nettype wire

//--- logic/result_select.sv
`timescale 1ns/1ns
`default_nettype none

`include "addr_decode_macros.svh"

module result_select (
    input  logic                                                clk,
    input  logic                                                rst_n,
    input  logic [`ADDR_OFFSET_W-1:0]                           offset,
    input  addr_decode_pkg::addr_info_t [`ADDR_MODRM_POSITIONS-1:0] candidates,
    input  logic                                                stage_valid,
    output logic                                                stage_ready,
    output addr_decode_pkg::addr_info_t                         out_info,
    output logic                                                out_valid,
    input  logic                                                out_ready
);

    import addr_decode_pkg::*;

    // decoder result at the ModRM position
    addr_info_t picked;
    // transfer from the window stage
    logic       stage_fire;

    // offset never exceeds the last position for legal prefix counts
    // anything beyond falls back to an empty result
    always_comb begin
        if (offset < `ADDR_OFFSET_W'(`ADDR_MODRM_POSITIONS)) begin
            picked = candidates[offset];
        end else begin
            picked = '0;
        end
    end

    // take a new item when the output is empty or being consumed
    assign stage_ready = !out_valid || out_ready;
    assign stage_fire  = stage_valid && stage_ready;

    // output valid holds while the consumer stalls
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else if (stage_fire) begin
            out_valid <= 1'b1;
        end else if (out_ready) begin
            out_valid <= 1'b0;
        end
    end

    // output payload, held unless a new item arrives
    always_ff @(posedge clk) begin
        if (stage_fire) begin
            out_info <= picked;
        end
    end

endmodule

`default_nettype wire

//--- logic/modrm_decoder.sv
`timescale 1ns/1ns
`default_nettype none

`include "addr_decode_macros.svh"

module modrm_decoder (
    input  logic [7:0]                 modrm_byte,
    input  logic [7:0]                 sib_byte,
    input  logic                       has_modrm,
    output addr_decode_pkg::addr_info_t info
);

    import addr_decode_pkg::*;

    // ModRM fields
    mod_mode_e  mod_field;
    logic [2:0] rm_field;
    // SIB fields
    logic [1:0] sib_scale;
    logic [2:0] sib_index;
    logic [2:0] sib_base;

    // rm selects of interest in 32-bit mode
    logic       rm_is_sib;
    logic       rm_is_disp32;
    // decoded SIB presence
    logic       is_sib;
    // indirect with rm 101 means disp32 and no base
    logic       abs_disp32;

    assign mod_field = mod_mode_e'(modrm_byte[7:6]);
    assign rm_field  = modrm_byte[2:0];
    assign sib_scale = sib_byte[7:6];
    assign sib_index = sib_byte[5:3];
    assign sib_base  = sib_byte[2:0];

    assign rm_is_sib    = (rm_field == 3'b100);
    assign rm_is_disp32 = (rm_field == 3'b101);

    // SIB follows any memory form with rm 100
    assign is_sib     = has_modrm && (mod_field != mod_register) && rm_is_sib;
    assign abs_disp32 = (mod_field == mod_indirect) && rm_is_disp32;

    // byte count of ModRM, SIB and displacement
    always_comb begin
        info.length = `ADDR_LEN_W'(0);
        if (has_modrm) begin
            case (mod_field)
                mod_indirect: begin
                    // SIB base 101 with mod 00 is not special cased here
                    if (is_sib) begin
                        info.length = `ADDR_LEN_W'(2);
                    end else if (rm_is_disp32) begin
                        info.length = `ADDR_LEN_W'(5);
                    end else begin
                        info.length = `ADDR_LEN_W'(1);
                    end
                end
                mod_disp8: begin
                    info.length = is_sib ? `ADDR_LEN_W'(3) : `ADDR_LEN_W'(2);
                end
                mod_disp32: begin
                    info.length = is_sib ? `ADDR_LEN_W'(6) : `ADDR_LEN_W'(5);
                end
                default: begin
                    // register operand, ModRM only
                    info.length = `ADDR_LEN_W'(1);
                end
            endcase
        end
    end

    // displacement size
    always_comb begin
        info.disp_size = disp_none;
        if (has_modrm) begin
            case (mod_field)
                mod_disp8:    info.disp_size = disp_8;
                mod_disp32:   info.disp_size = disp_32;
                mod_indirect: info.disp_size = rm_is_disp32 ? disp_32 : disp_none;
                default:      info.disp_size = disp_none;
            endcase
        end
    end

    // base register comes from SIB when present
    assign info.base_reg = is_sib ? sib_base : rm_field;
    // absolute disp32 form has no base
    assign info.use_base = has_modrm && !abs_disp32;

    // index and scale only mean something with SIB
    assign info.index_reg = sib_index;
    assign info.use_index = is_sib;
    assign info.scale     = is_sib ? sib_scale : 2'b00;
    assign info.is_sib    = is_sib;

endmodule

`default_nettype wire

//--- logic/window_capture.sv
`timescale 1ns/1ns
`default_nettype none

`include "addr_decode_macros.svh"

module window_capture (
    input  logic                          clk,
    input  logic                          rst_n,
    input  addr_decode_pkg::addr_req_t    in_req,
    input  logic                          in_valid,
    output logic                          in_ready,
    output addr_decode_pkg::window_stage_t stage,
    output logic                          stage_valid,
    input  logic                          stage_ready
);

    import addr_decode_pkg::*;

    // ModRM offset of the incoming request
    logic [`ADDR_OFFSET_W-1:0] req_offset;
    // registered form of the incoming request
    window_stage_t             next_stage;
    // upstream transfer this cycle
    logic                      in_fire;

    // ModRM sits after the prefixes and one extra opcode byte
    // for the two-byte opcode case
    always_comb begin
        req_offset = `ADDR_OFFSET_W'(in_req.prefix_count)
                   + `ADDR_OFFSET_W'(in_req.is_double_op);
    end

    // pack the fields the drain needs
    always_comb begin
        next_stage.window    = in_req.window;
        next_stage.offset    = req_offset;
        next_stage.has_modrm = in_req.has_modrm;
    end

    // ready when empty or when the held item leaves this cycle
    assign in_ready = !stage_valid || stage_ready;
    assign in_fire  = in_valid && in_ready;

    // valid bit of the single stage register
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            stage_valid <= 1'b0;
        end else if (in_fire) begin
            stage_valid <= 1'b1;
        end else if (stage_ready) begin
            // drained with nothing new behind it
            stage_valid <= 1'b0;
        end
    end

    // payload only moves on a transfer
    always_ff @(posedge clk) begin
        if (in_fire) begin
            stage <= next_stage;
        end
    end

endmodule

`default_nettype wire

//--- logic/addr_decode_pkg.sv
`default_nettype none

`include "addr_decode_macros.svh"

package addr_decode_pkg;

    // mod field of the ModRM byte, bits 7:6
    typedef enum logic [1:0] {
        mod_indirect = 2'b00,
        mod_disp8    = 2'b01,
        mod_disp32   = 2'b10,
        mod_register = 2'b11
    } mod_mode_e;

    // displacement bytes that follow ModRM/SIB
    typedef enum logic [1:0] {
        disp_none = 2'd0,
        disp_8    = 2'd1,
        disp_32   = 2'd2
    } disp_size_e;

    // one decode request from upstream
    // window[0] is the first byte after the opcode start
    typedef struct packed {
        logic [`ADDR_WINDOW_BYTES-1:0][7:0]           window;
        logic [$clog2(`ADDR_MAX_PREFIXES+1)-1:0]      prefix_count;
        logic                                         is_double_op;
        logic                                         has_modrm;
    } addr_req_t;

    // registered window held between the feeder and the drain
    // offset already points at the ModRM byte
    typedef struct packed {
        logic [`ADDR_WINDOW_BYTES-1:0][7:0]           window;
        logic [`ADDR_OFFSET_W-1:0]                    offset;
        logic                                         has_modrm;
    } window_stage_t;

    // decoded addressing information for one ModRM position
    typedef struct packed {
        // bytes taken by ModRM, SIB and displacement
        logic [`ADDR_LEN_W-1:0] length;
        disp_size_e             disp_size;
        // base register, from SIB base or ModRM rm
        logic [2:0]             base_reg;
        logic                   use_base;
        // index register, always the SIB index field
        logic [2:0]             index_reg;
        logic                   use_index;
        // index shift amount, zero without SIB
        logic [1:0]             scale;
        logic                   is_sib;
    } addr_info_t;

endpackage

`default_nettype wire

//--- logic/addr_decode_macros.svh
`ifndef ADDR_DECODE_MACROS_SVH
`define ADDR_DECODE_MACROS_SVH

// sizes shared by the address decode pipeline
// 32-bit addressing only

// instruction bytes seen after the opcode start
`define ADDR_WINDOW_BYTES 6

// candidate ModRM positions in the window
// the last position still needs one byte after it for the SIB
`define ADDR_MODRM_POSITIONS 5

// largest number of prefix bytes in front of the opcode
`define ADDR_MAX_PREFIXES 3

// width of a ModRM position index
// prefix count plus one for a two-byte opcode gives 0 to 4
`define ADDR_OFFSET_W 3

// width of the ModRM + SIB + displacement byte count
// largest case is disp32 with SIB, six bytes
`define ADDR_LEN_W 3

`endif
